// ==== verilog/pcie_dllp_pkg.sv ====
// DLLP type codes, InitFC body layout and CRC constants for the flow-control init logic
package pcie_dllp_pkg;

  // low three bits of the type byte carry the VC
  typedef enum logic [7:0] {
    InitFC1_P   = 8'h40,
    InitFC1_NP  = 8'h50,
    InitFC1_Cpl = 8'h60,
    InitFC2_P   = 8'hC0,
    InitFC2_NP  = 8'hD0,
    InitFC2_Cpl = 8'hE0
  } dllp_type_e;

  // first beat of an InitFC DLLP
  typedef struct packed {
    dllp_type_e  dtype;
    logic [1:0]  rsvd_hi;
    logic [7:0]  hdr;
    logic [1:0]  rsvd_lo;
    logic [11:0] data;
  } dllp_fc_t;

  localparam logic [15:0] DLLP_CRC_POLY = 16'h100B;
  localparam logic [15:0] DLLP_CRC_INIT = 16'hFFFF;

  // header credits we advertise for P and NP
  localparam logic [7:0] HDR_MIN_CREDITS = 8'd1;

endpackage

// ==== verilog/pcie_fc_pkg.sv ====
// flow-control credit types and transmit init states used by the FC init blocks
package pcie_fc_pkg;

  typedef logic [7:0]  hdr_credit_t;
  typedef logic [11:0] data_credit_t;

  // limits advertised by the partner for one class
  typedef struct packed {
    hdr_credit_t  hdr;
    data_credit_t data;
  } fc_credits_t;

  // listed in send order, each CRC state directly after its body state
  typedef enum logic [3:0] {
    ST_IDLE,
    ST_FC1_P_CRC,
    ST_FC1_NP,
    ST_FC1_NP_CRC,
    ST_FC1_CPL,
    ST_FC1_CPL_CRC,
    ST_FC1_CHECK,
    ST_FC2_P,
    ST_FC2_P_CRC,
    ST_FC2_NP,
    ST_FC2_NP_CRC,
    ST_FC2_CPL,
    ST_FC2_CPL_CRC,
    ST_FC2_CHECK,
    ST_DONE
  } fc_init_state_e;

endpackage

// ==== verilog/dllp_crc16.sv ====
// combinational DLLP CRC-16 of one body beat, returned as it is placed on the wire
`timescale 1ns/1ps
module dllp_crc16
  import pcie_dllp_pkg::*;
(
  input  dllp_fc_t    dllp_i,
  output logic [15:0] crc_o
);

  logic [31:0] data;
  logic [15:0] rem;
  logic [15:0] inv;

  assign data = dllp_i;

  // msb of byte 0 goes in first
  always_comb begin
    rem = DLLP_CRC_INIT;
    for (int i = 31; i >= 0; i--) begin
      if (rem[15] ^ data[i]) begin
        rem = {rem[14:0], 1'b0} ^ DLLP_CRC_POLY;
      end else begin
        rem = {rem[14:0], 1'b0};
      end
    end
  end

  assign inv = ~rem;

  // bit order flipped inside each byte
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      crc_o[b]     = inv[7-b];
      crc_o[8+b]   = inv[15-b];
    end
  end

endmodule

// ==== verilog/axis_skid_buffer.sv ====
// two-entry AXI-Stream register slice with registered ready toward the producer
`timescale 1ns/1ps
module axis_skid_buffer #(
  parameter int WIDTH = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [WIDTH-1:0] s_data_i,
  input  logic             s_valid_i,
  output logic             s_ready_o,
  output logic [WIDTH-1:0] m_data_o,
  output logic             m_valid_o,
  input  logic             m_ready_i
);

  logic [WIDTH-1:0] skid_data_q;
  logic             skid_valid_q;
  logic             s_fire;
  logic             load_main;

  assign s_fire    = s_valid_i && s_ready_o;
  // main register is empty or drains this cycle
  assign load_main = !m_valid_o || m_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      m_valid_o    <= 1'b0;
      skid_valid_q <= 1'b0;
      s_ready_o    <= 1'b0;
    end else begin
      if (load_main) begin
        // skid entry moves up first, s_ready is low while it is full
        m_valid_o    <= skid_valid_q || s_fire;
        skid_valid_q <= 1'b0;
        s_ready_o    <= 1'b1;
      end else begin
        skid_valid_q <= skid_valid_q || s_fire;
        s_ready_o    <= !(skid_valid_q || s_fire);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      m_data_o <= skid_valid_q ? skid_data_q : s_data_i;
    end
    // output stalled, park the accepted beat
    if (!load_main && s_fire) begin
      skid_data_q <= s_data_i;
    end
  end

endmodule

// ==== verilog/pcie_fc_init.sv ====
// sends InitFC1 then InitFC2 DLLPs for P, NP and Cpl until the partner's FC phases complete
`timescale 1ns/1ps
module pcie_fc_init
  import pcie_dllp_pkg::*;
  import pcie_fc_pkg::*;
#(
  parameter int FC_WAIT_CYCLES   = 16,
  parameter int MAX_PAYLOAD_SIZE = 256
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  logic        fc1_done_i,
  input  logic        fc2_done_i,
  input  logic        fc_tready_i,
  output logic [31:0] fc_tdata_o,
  output logic [3:0]  fc_tkeep_o,
  output logic        fc_tlast_o,
  output logic        fc_tvalid_o,
  output logic        init_ack_o,
  output logic        fc_init_done_o
);

  localparam int               CNT_W      = $clog2(FC_WAIT_CYCLES + 1);
  localparam logic [CNT_W-1:0] WAIT_MAX   = CNT_W'(FC_WAIT_CYCLES);
  localparam data_credit_t     PD_CREDITS = data_credit_t'(MAX_PAYLOAD_SIZE / 16);
  localparam data_credit_t     NP_DATA    = data_credit_t'(HDR_MIN_CREDITS);

  fc_init_state_e   state_q;
  fc_init_state_e   state_d;
  logic [CNT_W-1:0] wait_cnt_q;
  logic             wait_done;
  logic             crc_beat;
  logic             fc_fire;
  dllp_fc_t         body;
  logic [15:0]      body_crc;
  logic [15:0]      crc_q;

  function automatic dllp_fc_t make_body(dllp_type_e kind, hdr_credit_t hdr,
                                         data_credit_t data);
    dllp_fc_t b;
    b       = '0;
    b.dtype = kind;
    b.hdr   = hdr;
    b.data  = data;
    return b;
  endfunction

  always_comb begin
    case (state_q)
      ST_FC1_NP:  body = make_body(InitFC1_NP, HDR_MIN_CREDITS, NP_DATA);
      ST_FC1_CPL: body = make_body(InitFC1_Cpl, '0, PD_CREDITS);
      ST_FC2_P:   body = make_body(InitFC2_P, HDR_MIN_CREDITS, PD_CREDITS);
      ST_FC2_NP:  body = make_body(InitFC2_NP, HDR_MIN_CREDITS, NP_DATA);
      ST_FC2_CPL: body = make_body(InitFC2_Cpl, '0, PD_CREDITS);
      default:    body = make_body(InitFC1_P, HDR_MIN_CREDITS, PD_CREDITS);
    endcase
  end

  dllp_crc16 u_crc (
    .dllp_i (body),
    .crc_o  (body_crc)
  );

  assign wait_done = (wait_cnt_q == WAIT_MAX);
  assign fc_fire   = fc_tvalid_o && fc_tready_i;

  always_comb begin
    state_d     = state_q;
    fc_tvalid_o = 1'b0;
    crc_beat    = 1'b0;
    case (state_q)
      ST_IDLE: begin
        fc_tvalid_o = start_i && fc_tready_i;
        if (start_i && fc_tready_i) begin
          state_d = ST_FC1_P_CRC;
        end
      end
      // body held back until the gap since the last CRC beat has passed
      ST_FC1_NP, ST_FC1_CPL, ST_FC2_P, ST_FC2_NP, ST_FC2_CPL: begin
        fc_tvalid_o = wait_done;
        if (wait_done && fc_tready_i) begin
          state_d = fc_init_state_e'(state_q + 4'd1);
        end
      end
      ST_FC1_P_CRC, ST_FC1_NP_CRC, ST_FC1_CPL_CRC,
      ST_FC2_P_CRC, ST_FC2_NP_CRC, ST_FC2_CPL_CRC: begin
        crc_beat    = 1'b1;
        fc_tvalid_o = 1'b1;
        if (fc_tready_i) begin
          state_d = fc_init_state_e'(state_q + 4'd1);
        end
      end
      ST_FC1_CHECK: begin
        if (fc1_done_i) begin
          state_d = ST_FC2_P;
        end else if (wait_done) begin
          state_d = ST_IDLE;
        end
      end
      ST_FC2_CHECK: begin
        if (fc2_done_i) begin
          state_d = ST_DONE;
        end else if (wait_done) begin
          state_d = ST_FC2_P;
        end
      end
      default: begin
        state_d = state_q;
      end
    endcase
  end

  assign fc_tdata_o     = crc_beat ? {16'h0000, crc_q} : body;
  assign fc_tkeep_o     = crc_beat ? 4'b0011 : 4'b1111;
  assign fc_tlast_o     = crc_beat;
  assign init_ack_o     = (state_q == ST_IDLE) && start_i && fc_tready_i;
  assign fc_init_done_o = (state_q == ST_DONE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= ST_IDLE;
      wait_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // gap and check timeout both count from the CRC transfer
      if (fc_fire && crc_beat) begin
        wait_cnt_q <= '0;
      end else if (!wait_done) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fc_fire && !crc_beat) begin
      crc_q <= body_crc;
    end
  end

endmodule

// ==== verilog/fc_rx_credit_store.sv ====
// parses partner InitFC DLLPs, checks CRC and keeps the advertised credit limits
`timescale 1ns/1ps
module fc_rx_credit_store
  import pcie_dllp_pkg::*;
  import pcie_fc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic [31:0]  s_axis_tdata_i,
  input  logic [3:0]   s_axis_tkeep_i,
  input  logic         s_axis_tlast_i,
  input  logic         s_axis_tvalid_i,
  output logic         s_axis_tready_o,
  output logic         fc1_done_o,
  output logic         fc2_done_o,
  output hdr_credit_t  p_hdr_o,
  output data_credit_t p_data_o,
  output hdr_credit_t  np_hdr_o,
  output data_credit_t np_data_o,
  output hdr_credit_t  cpl_hdr_o,
  output data_credit_t cpl_data_o
);

  dllp_fc_t    body_q;
  logic        crc_beat_q;
  logic [15:0] body_crc;
  logic        s_fire;
  logic [7:0]  kind;
  logic        vc0;
  logic        is_p;
  logic        is_np;
  logic        is_cpl;
  logic        dllp_ok;
  fc_credits_t rx_cred;
  fc_credits_t p_q;
  fc_credits_t np_q;
  fc_credits_t cpl_q;
  logic        p_seen_q;
  logic        np_seen_q;
  logic        cpl_seen_q;
  logic        fc2_seen_q;

  dllp_crc16 u_crc (
    .dllp_i (body_q),
    .crc_o  (body_crc)
  );

  assign s_fire = s_axis_tvalid_i && s_axis_tready_o;
  assign kind   = {body_q.dtype[7:3], 3'b000};
  assign vc0    = (body_q.dtype[2:0] == 3'b000);
  assign is_p   = (kind == InitFC1_P) || (kind == InitFC2_P);
  assign is_np  = (kind == InitFC1_NP) || (kind == InitFC2_NP);
  assign is_cpl = (kind == InitFC1_Cpl) || (kind == InitFC2_Cpl);

  assign dllp_ok = s_fire && crc_beat_q && s_axis_tlast_i && (s_axis_tkeep_i == 4'b0011) &&
                   (s_axis_tdata_i[15:0] == body_crc) && vc0 && (is_p || is_np || is_cpl);

  assign rx_cred = '{hdr: body_q.hdr, data: body_q.data};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s_axis_tready_o <= 1'b0;
      crc_beat_q      <= 1'b0;
      p_q             <= '0;
      np_q            <= '0;
      cpl_q           <= '0;
      p_seen_q        <= 1'b0;
      np_seen_q       <= 1'b0;
      cpl_seen_q      <= 1'b0;
      fc2_seen_q      <= 1'b0;
    end else begin
      s_axis_tready_o <= 1'b1;
      // a beat after tlast always starts a new DLLP
      if (s_fire) begin
        crc_beat_q <= !s_axis_tlast_i;
      end
      if (dllp_ok) begin
        if (is_p) begin
          p_q      <= rx_cred;
          p_seen_q <= 1'b1;
        end
        if (is_np) begin
          np_q      <= rx_cred;
          np_seen_q <= 1'b1;
        end
        if (is_cpl) begin
          cpl_q      <= rx_cred;
          cpl_seen_q <= 1'b1;
        end
        // top bit of the type marks InitFC2
        if (kind[7]) begin
          fc2_seen_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s_fire && !s_axis_tlast_i) begin
      body_q <= s_axis_tdata_i;
    end
  end

  assign fc1_done_o = p_seen_q && np_seen_q && cpl_seen_q;
  assign fc2_done_o = fc1_done_o && fc2_seen_q;

  assign p_hdr_o    = p_q.hdr;
  assign p_data_o   = p_q.data;
  assign np_hdr_o   = np_q.hdr;
  assign np_data_o  = np_q.data;
  assign cpl_hdr_o  = cpl_q.hdr;
  assign cpl_data_o = cpl_q.data;

endmodule

// ==== verilog/pcie_fc_top.sv ====
// flow-control init top: InitFC transmitter, output skid buffer and partner credit receiver
`timescale 1ns/1ps
module pcie_fc_top
  import pcie_fc_pkg::*;
#(
  parameter int FC_WAIT_CYCLES   = 16,
  parameter int MAX_PAYLOAD_SIZE = 256
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         start_i,
  output logic [31:0]  m_axis_tdata_o,
  output logic [3:0]   m_axis_tkeep_o,
  output logic         m_axis_tlast_o,
  output logic         m_axis_tvalid_o,
  input  logic         m_axis_tready_i,
  input  logic [31:0]  s_axis_tdata_i,
  input  logic [3:0]   s_axis_tkeep_i,
  input  logic         s_axis_tlast_i,
  input  logic         s_axis_tvalid_i,
  output logic         s_axis_tready_o,
  output logic         init_ack_o,
  output logic         fc_init_done_o,
  output logic         fc1_done_o,
  output logic         fc2_done_o,
  output hdr_credit_t  p_hdr_o,
  output data_credit_t p_data_o,
  output hdr_credit_t  np_hdr_o,
  output data_credit_t np_data_o,
  output hdr_credit_t  cpl_hdr_o,
  output data_credit_t cpl_data_o
);

  // tdata, tkeep and tlast through the slice
  localparam int SKID_W = 32 + 4 + 1;

  logic [31:0]       fc_tdata;
  logic [3:0]        fc_tkeep;
  logic              fc_tlast;
  logic              fc_tvalid;
  logic              fc_tready;
  logic [SKID_W-1:0] skid_out;

  pcie_fc_init #(
    .FC_WAIT_CYCLES   (FC_WAIT_CYCLES),
    .MAX_PAYLOAD_SIZE (MAX_PAYLOAD_SIZE)
  ) u_fc_init (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .start_i        (start_i),
    .fc1_done_i     (fc1_done_o),
    .fc2_done_i     (fc2_done_o),
    .fc_tready_i    (fc_tready),
    .fc_tdata_o     (fc_tdata),
    .fc_tkeep_o     (fc_tkeep),
    .fc_tlast_o     (fc_tlast),
    .fc_tvalid_o    (fc_tvalid),
    .init_ack_o     (init_ack_o),
    .fc_init_done_o (fc_init_done_o)
  );

  axis_skid_buffer #(
    .WIDTH (SKID_W)
  ) u_skid (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s_data_i  ({fc_tdata, fc_tkeep, fc_tlast}),
    .s_valid_i (fc_tvalid),
    .s_ready_o (fc_tready),
    .m_data_o  (skid_out),
    .m_valid_o (m_axis_tvalid_o),
    .m_ready_i (m_axis_tready_i)
  );

  assign m_axis_tdata_o = skid_out[SKID_W-1:5];
  assign m_axis_tkeep_o = skid_out[4:1];
  assign m_axis_tlast_o = skid_out[0];

  fc_rx_credit_store u_rx (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tkeep_i  (s_axis_tkeep_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tready_o (s_axis_tready_o),
    .fc1_done_o      (fc1_done_o),
    .fc2_done_o      (fc2_done_o),
    .p_hdr_o         (p_hdr_o),
    .p_data_o        (p_data_o),
    .np_hdr_o        (np_hdr_o),
    .np_data_o       (np_data_o),
    .cpl_hdr_o       (cpl_hdr_o),
    .cpl_data_o      (cpl_data_o)
  );

endmodule

// ==== testbench/pcie_fc_checker.sv ====
// protocol assertions on the InitFC transmit stream and init status, bound into the FC top
`timescale 1ns/1ps
module pcie_fc_checker
  import pcie_dllp_pkg::*;
(
  input logic        clk_i,
  input logic        rst_i,
  input logic [31:0] tdata_i,
  input logic [3:0]  tkeep_i,
  input logic        tlast_i,
  input logic        tvalid_i,
  input logic        tready_i,
  input logic        init_ack_i,
  input logic        init_done_i,
  input logic        fc2_done_i
);

  int unsigned fail_cnt = 0;
  logic [31:0] body_q;
  logic [2:0]  exp_cls_q;
  logic        set_fc2_q;
  logic        fc2_seen_q;
  logic        expect_crc_q;
  logic        beat_fire;
  logic        body_fire;
  logic        crc_fire;
  logic        type_ok;

  // crc as it appears on the wire
  function automatic logic [15:0] ref_crc(input logic [31:0] body);
    logic [15:0] r;
    logic [15:0] c;
    r = DLLP_CRC_INIT;
    for (int i = 31; i >= 0; i--) begin
      r = {r[14:0], 1'b0} ^ (((r[15] ^ body[i]) != 1'b0) ? DLLP_CRC_POLY : 16'h0000);
    end
    r = ~r;
    for (int b = 0; b < 8; b++) begin
      c[b]   = r[7-b];
      c[8+b] = r[15-b];
    end
    return c;
  endfunction

  assign beat_fire = tvalid_i && tready_i;
  assign body_fire = beat_fire && !tlast_i;
  assign crc_fire  = beat_fire && tlast_i;

  // P opens a set, NP and Cpl must match its FC phase
  assign type_ok = (tdata_i[30:28] == exp_cls_q) && (tdata_i[27:24] == 4'h0) &&
                   ((tdata_i[30:28] == 3'd4) ? (!fc2_seen_q || tdata_i[31])
                                             : (tdata_i[31] == set_fc2_q));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exp_cls_q    <= 3'd4;
      set_fc2_q    <= 1'b0;
      fc2_seen_q   <= 1'b0;
      expect_crc_q <= 1'b0;
    end else begin
      if (beat_fire) begin
        expect_crc_q <= !tlast_i;
      end
      if (body_fire) begin
        body_q    <= tdata_i;
        exp_cls_q <= (exp_cls_q == 3'd6) ? 3'd4 : exp_cls_q + 3'd1;
        if (tdata_i[30:28] == 3'd4) begin
          set_fc2_q <= tdata_i[31];
        end
        if (tdata_i[31]) begin
          fc2_seen_q <= 1'b1;
        end
      end
    end
  end

  a_ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    init_ack_i |=> !init_ack_i)
    else begin $error("init_ack_o longer than one cycle"); fail_cnt++; end

  a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i) && $stable(tkeep_i) &&
                              $stable(tlast_i))
    else begin $error("stalled beat changed or dropped"); fail_cnt++; end

  a_alternate: assert property (@(posedge clk_i) disable iff (rst_i)
    beat_fire |-> (tlast_i == expect_crc_q))
    else begin $error("body and crc beats out of order"); fail_cnt++; end

  a_body_keep: assert property (@(posedge clk_i) disable iff (rst_i)
    body_fire |-> (tkeep_i == 4'b1111) && type_ok)
    else begin $error("body beat with wrong keep or type order"); fail_cnt++; end

  a_crc_beat: assert property (@(posedge clk_i) disable iff (rst_i)
    crc_fire |-> (tkeep_i == 4'b0011) && (tdata_i == {16'h0000, ref_crc(body_q)}))
    else begin $error("crc beat does not match preceding body"); fail_cnt++; end

  a_done_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    init_done_i |=> init_done_i)
    else begin $error("fc_init_done_o dropped"); fail_cnt++; end

  a_done_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    init_done_i |-> fc2_done_i && !(tvalid_i && !tlast_i))
    else begin $error("DLLP body or missing fc2_done_o after init done"); fail_cnt++; end

endmodule

// ==== testbench/pcie_fc_tb.sv ====
// top-level testbench for the FC init design that drives start, sink ready and partner DLLPs
`timescale 1ns/1ps
module pcie_fc_tb
  import pcie_dllp_pkg::*;
();

  localparam int FC_WAIT         = 16;
  localparam int MPS             = 256;
  localparam int N_TESTS         = 4;
  localparam int WATCHDOG_CYCLES = N_TESTS * 6 * 8 * FC_WAIT + 500;

  logic        clk_i;
  logic        rst_i;
  logic        start_i;
  logic [31:0] m_axis_tdata_o;
  logic [3:0]  m_axis_tkeep_o;
  logic        m_axis_tlast_o;
  logic        m_axis_tvalid_o;
  logic        m_axis_tready_i;
  logic [31:0] s_axis_tdata_i;
  logic [3:0]  s_axis_tkeep_i;
  logic        s_axis_tlast_i;
  logic        s_axis_tvalid_i;
  logic        s_axis_tready_o;
  logic        init_ack_o;
  logic        fc_init_done_o;
  logic        fc1_done_o;
  logic        fc2_done_o;
  logic [7:0]  p_hdr_o;
  logic [11:0] p_data_o;
  logic [7:0]  np_hdr_o;
  logic [11:0] np_data_o;
  logic [7:0]  cpl_hdr_o;
  logic [11:0] cpl_data_o;

  integer      seed;
  logic [31:0] rnd;
  logic [31:0] rdy_rnd;
  int          stall;
  int          errors;
  int          test_errs;
  int          tests;
  int          failed;
  int          acks;
  int          fc1_bodies;
  int          fc2_bodies;
  int          sent_bodies;
  logic [7:0]  exp_hdr [3];
  logic [11:0] exp_data [3];

  pcie_fc_top #(
    .FC_WAIT_CYCLES   (FC_WAIT),
    .MAX_PAYLOAD_SIZE (MPS)
  ) uut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .start_i         (start_i),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tkeep_o  (m_axis_tkeep_o),
    .m_axis_tlast_o  (m_axis_tlast_o),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tready_i (m_axis_tready_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .s_axis_tkeep_i  (s_axis_tkeep_i),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tready_o (s_axis_tready_o),
    .init_ack_o      (init_ack_o),
    .fc_init_done_o  (fc_init_done_o),
    .fc1_done_o      (fc1_done_o),
    .fc2_done_o      (fc2_done_o),
    .p_hdr_o         (p_hdr_o),
    .p_data_o        (p_data_o),
    .np_hdr_o        (np_hdr_o),
    .np_data_o       (np_data_o),
    .cpl_hdr_o       (cpl_hdr_o),
    .cpl_data_o      (cpl_data_o)
  );

  bind pcie_fc_top pcie_fc_checker u_checker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .tdata_i     (m_axis_tdata_o),
    .tkeep_i     (m_axis_tkeep_o),
    .tlast_i     (m_axis_tlast_o),
    .tvalid_i    (m_axis_tvalid_o),
    .tready_i    (m_axis_tready_i),
    .init_ack_i  (init_ack_o),
    .init_done_i (fc_init_done_o),
    .fc2_done_i  (fc2_done_o)
  );

  // DLLP CRC in wire order from an all-ones start
  function automatic logic [15:0] wire_crc(input logic [31:0] body);
    logic [15:0] r;
    logic [15:0] c;
    r = 16'hFFFF;
    for (int i = 31; i >= 0; i--) begin
      r = {r[14:0], 1'b0} ^ (((r[15] ^ body[i]) != 1'b0) ? 16'h100B : 16'h0000);
    end
    r = ~r;
    for (int b = 0; b < 8; b++) begin
      c[b]   = r[7-b];
      c[8+b] = r[15-b];
    end
    return c;
  endfunction

  function automatic int all_errors();
    return errors + int'(uut.u_checker.fail_cnt);
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // credit fields follow the advertised limits of each class
  task automatic check_body(input logic [31:0] body);
    logic [2:0] cls;
    cls = body[30:28];
    expect_eq("m_axis_tdata_o hdr credits", body[21:14],
              (cls == 3'd6) ? 8'd0 : HDR_MIN_CREDITS);
    expect_eq("m_axis_tdata_o data credits", body[11:0],
              (cls == 3'd5) ? 12'(HDR_MIN_CREDITS) : 12'(MPS / 16));
    expect_eq("m_axis_tdata_o reserved bits", {body[23:22], body[13:12]}, 4'd0);
  endtask

  task automatic check_credits();
    expect_eq("p_hdr_o", p_hdr_o, exp_hdr[0]);
    expect_eq("p_data_o", p_data_o, exp_data[0]);
    expect_eq("np_hdr_o", np_hdr_o, exp_hdr[1]);
    expect_eq("np_data_o", np_data_o, exp_data[1]);
    expect_eq("cpl_hdr_o", cpl_hdr_o, exp_hdr[2]);
    expect_eq("cpl_data_o", cpl_data_o, exp_data[2]);
  endtask

  task automatic send_beat(input logic [31:0] d, input logic [3:0] k, input logic l);
    s_axis_tdata_i  <= d;
    s_axis_tkeep_i  <= k;
    s_axis_tlast_i  <= l;
    s_axis_tvalid_i <= 1'b1;
    @(posedge clk_i);
    while (!s_axis_tready_o) begin
      @(posedge clk_i);
    end
  endtask

  // returns one cycle after the CRC beat when credits are visible
  task automatic send_dllp(input logic [7:0] kind, input logic [7:0] hdr,
                           input logic [11:0] data, input logic corrupt);
    logic [31:0] body;
    logic [15:0] crc;
    body = {kind, 2'b00, hdr, 2'b00, data};
    crc  = wire_crc(body) ^ {15'd0, corrupt};
    send_beat(body, 4'b1111, 1'b0);
    send_beat({16'h0000, crc}, 4'b0011, 1'b1);
    s_axis_tvalid_i <= 1'b0;
    @(posedge clk_i);
    expect_eq("s_axis_tready_o", s_axis_tready_o, 1'b1);
  endtask

  task automatic send_and_check(input logic [7:0] kind, input logic [7:0] hdr,
                                input logic [11:0] data);
    send_dllp(kind, hdr, data, 1'b0);
    exp_hdr[kind[6:4] - 3'd4]  = hdr;
    exp_data[kind[6:4] - 3'd4] = data;
    check_credits();
  endtask

  task automatic end_test(input string name);
    tests++;
    if (all_errors() == test_errs) begin
      $display("%s: pass", name);
    end else begin
      failed++;
      $display("%s: fail with %0d errors", name, all_errors() - test_errs);
    end
    test_errs = all_errors();
  endtask

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // random sink ready with occasional longer stalls
  initial begin
    m_axis_tready_i = 1'b0;
    stall           = 0;
    forever begin
      @(negedge clk_i);
      rdy_rnd = $random(seed);
      @(posedge clk_i);
      if (stall > 0) begin
        m_axis_tready_i <= 1'b0;
        stall = stall - 1;
      end else if (rdy_rnd[5:0] == 6'd0) begin
        stall = 3 + int'(rdy_rnd[9:7]);
        m_axis_tready_i <= 1'b0;
      end else begin
        m_axis_tready_i <= (rdy_rnd[1:0] != 2'b00);
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_i && init_ack_o) begin
      acks <= acks + 1;
    end
    if (!rst_i && m_axis_tvalid_o && m_axis_tready_i && !m_axis_tlast_o) begin
      check_body(m_axis_tdata_o);
      if (m_axis_tdata_o[31]) begin
        fc2_bodies <= fc2_bodies + 1;
      end else begin
        fc1_bodies <= fc1_bodies + 1;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

  initial begin
    seed            = 32'h47dd_5404;
    rst_i           = 1'b1;
    start_i         = 1'b0;
    s_axis_tdata_i  = '0;
    s_axis_tkeep_i  = '0;
    s_axis_tlast_i  = 1'b0;
    s_axis_tvalid_i = 1'b0;
    errors          = 0;
    test_errs       = 0;
    tests           = 0;
    failed          = 0;
    acks            = 0;
    fc1_bodies      = 0;
    fc2_bodies      = 0;
    for (int c = 0; c < 3; c++) begin
      exp_hdr[c]  = '0;
      exp_data[c] = '0;
    end
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    check_credits();
    expect_eq("s_axis_tready_o", s_axis_tready_o, 1'b0);
    expect_eq("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
    expect_eq("fc_init_done_o", fc_init_done_o, 1'b0);
    expect_eq("fc1_done_o", fc1_done_o, 1'b0);
    expect_eq("fc2_done_o", fc2_done_o, 1'b0);

    // silent partner makes the FC1 set go out twice
    start_i <= 1'b1;
    while (fc1_bodies < 6) begin
      @(posedge clk_i);
    end
    expect_eq("init_ack_o pulse count", acks, 2);
    expect_eq("InitFC2 bodies sent", fc2_bodies, 0);
    end_test("fc1 sequence and retry");

    send_dllp(InitFC1_P, 8'h2A, 12'h155, 1'b1);
    check_credits();
    expect_eq("fc1_done_o", fc1_done_o, 1'b0);
    end_test("corrupted crc ignored");

    for (int c = 0; c < 3; c++) begin
      rnd = $random(seed);
      send_and_check(8'h40 + 8'(c * 16), rnd[7:0], rnd[19:8]);
    end
    expect_eq("fc1_done_o", fc1_done_o, 1'b1);
    expect_eq("fc2_done_o", fc2_done_o, 1'b0);
    while (fc2_bodies == 0) begin
      @(posedge clk_i);
    end
    end_test("partner fc1 credits");

    rnd = $random(seed);
    send_and_check(InitFC2_NP, rnd[7:0], rnd[19:8]);
    expect_eq("fc2_done_o", fc2_done_o, 1'b1);
    while (!fc_init_done_o) begin
      @(posedge clk_i);
    end
    sent_bodies = fc1_bodies + fc2_bodies;
    repeat (4 * FC_WAIT) @(posedge clk_i);
    expect_eq("bodies sent after done", fc1_bodies + fc2_bodies, sent_bodies);
    expect_eq("fc_init_done_o", fc_init_done_o, 1'b1);
    end_test("fc2 and init done");

    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion errors",
             tests, failed, errors, uut.u_checker.fail_cnt);
    if (failed == 0 && all_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/pcie_dllp_pkg.sv
verilog/pcie_fc_pkg.sv
verilog/dllp_crc16.sv
verilog/axis_skid_buffer.sv
verilog/pcie_fc_init.sv
verilog/fc_rx_credit_store.sv
verilog/pcie_fc_top.sv
testbench/pcie_fc_checker.sv
testbench/pcie_fc_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FC init testbench with Verilator, run from the project root
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pcie_fc_tb \
  -f sim.f -o pcie_fc_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/pcie_fc_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
exit 0
